// File: btac_top.f
logic/btac_pkg.sv
logic/btb_port_if.sv
logic/target_store.sv
logic/target_lookup.sv
logic/miss_resolver.sv
logic/fetch_steer.sv
logic/btac_top.sv
verif/btac_tb.sv

// File: build.sh
#!/bin/sh
# compile and run the btac testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f btac_top.f --top-module btac_tb -o btac_sim
./obj_dir/btac_sim | tee sim.log
if grep -q "^Regression passed$" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported a failure"
  exit 1
fi

// File: logic/btac_pkg.sv
package btac_pkg;

  localparam int btb_entries = 64;
  localparam int btb_index_width = $clog2(btb_entries); // index from pc[7:2]
  localparam int xlen = 32;

  // one buffer entry with the target in the top word
  typedef struct packed {
    logic [xlen-1:0] target; // taken target address
    logic [xlen-1:0] pc;     // branch pc compared as the tag
    logic [xlen-1:0] npc;    // fall-through pc
  } btb_entry_t;

  // fetch prediction for a slot as returned with the resolved branch
  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] tpc;   // predicted branch pc
    logic [xlen-1:0] taddr; // predicted target
    logic [xlen-1:0] tnpc;  // fall-through of the predicted branch
  } pred_info_t;

endpackage

// File: logic/btac_top.sv
`timescale 1ns/10ps

module btac_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      stall,
  input  logic [btac_pkg::xlen-1:0] fetch_pc0,
  input  logic [btac_pkg::xlen-1:0] fetch_pc1,
  input  logic [btac_pkg::xlen-1:0] upd_pc0,
  input  logic [btac_pkg::xlen-1:0] upd_npc0,
  input  logic [btac_pkg::xlen-1:0] upd_addr0,
  input  logic                      upd_jal0,
  input  logic                      upd_branch0,
  input  logic                      upd_jump0,
  input  logic                      upd_taken0,
  input  logic [btac_pkg::xlen-1:0] upd_tpc0,
  input  logic [btac_pkg::xlen-1:0] upd_taddr0,
  input  logic [btac_pkg::xlen-1:0] upd_tnpc0,
  input  logic [btac_pkg::xlen-1:0] upd_pc1,
  input  logic [btac_pkg::xlen-1:0] upd_npc1,
  input  logic [btac_pkg::xlen-1:0] upd_addr1,
  input  logic                      upd_jal1,
  input  logic                      upd_branch1,
  input  logic                      upd_jump1,
  input  logic                      upd_taken1,
  input  logic [btac_pkg::xlen-1:0] upd_tpc1,
  input  logic [btac_pkg::xlen-1:0] upd_taddr1,
  input  logic [btac_pkg::xlen-1:0] upd_tnpc1,
  output logic                      pred_branch0,
  output logic                      pred_branch1,
  output logic [btac_pkg::xlen-1:0] pred_baddr,
  output logic [btac_pkg::xlen-1:0] pred_pc,
  output logic [btac_pkg::xlen-1:0] pred_npc,
  output logic                      redirect,
  output logic [btac_pkg::xlen-1:0] redirect_addr,
  output logic                      hazard0,
  output logic                      hazard1
);

  btac_pkg::pred_info_t upd_pred0;
  btac_pkg::pred_info_t upd_pred1;
  logic                 hit0;
  logic                 hit1;
  btac_pkg::btb_entry_t entry0;
  btac_pkg::btb_entry_t entry1;

  assign upd_pred0 = '{taken: upd_taken0, tpc: upd_tpc0, taddr: upd_taddr0, tnpc: upd_tnpc0};
  assign upd_pred1 = '{taken: upd_taken1, tpc: upd_tpc1, taddr: upd_taddr1, tnpc: upd_tnpc1};

  btb_port_if btb_port ();

  target_store u_store (
    .clock (clock),
    .reset (reset),
    .port  (btb_port.store)
  );

  target_lookup u_lookup (
    .clock     (clock),
    .reset     (reset),
    .clear     (clear),
    .fetch_pc0 (fetch_pc0),
    .fetch_pc1 (fetch_pc1),
    .port      (btb_port.lookup),
    .hit0      (hit0),
    .hit1      (hit1),
    .entry0    (entry0),
    .entry1    (entry1)
  );

  miss_resolver u_resolver (
    .clock         (clock),
    .reset         (reset),
    .clear         (clear),
    .upd_pc0       (upd_pc0),
    .upd_pc1       (upd_pc1),
    .upd_npc0      (upd_npc0),
    .upd_npc1      (upd_npc1),
    .upd_addr0     (upd_addr0),
    .upd_addr1     (upd_addr1),
    .upd_jal0      (upd_jal0),
    .upd_jal1      (upd_jal1),
    .upd_branch0   (upd_branch0),
    .upd_branch1   (upd_branch1),
    .upd_jump0     (upd_jump0),
    .upd_jump1     (upd_jump1),
    .upd_pred0     (upd_pred0),
    .upd_pred1     (upd_pred1),
    .port          (btb_port.update),
    .redirect      (redirect),
    .redirect_addr (redirect_addr),
    .hazard0       (hazard0),
    .hazard1       (hazard1)
  );

  fetch_steer u_steer (
    .stall        (stall),
    .clear        (clear),
    .redirect     (redirect), // registered miss masks the next fetch group
    .hit0         (hit0),
    .hit1         (hit1),
    .entry0       (entry0),
    .entry1       (entry1),
    .pred_branch0 (pred_branch0),
    .pred_branch1 (pred_branch1),
    .pred_baddr   (pred_baddr),
    .pred_pc      (pred_pc),
    .pred_npc     (pred_npc)
  );

endmodule

// File: logic/btb_port_if.sv
`timescale 1ns/10ps

interface btb_port_if;

  logic                                 wen;
  logic [btac_pkg::btb_index_width-1:0] waddr;
  btac_pkg::btb_entry_t                 wdata;

  logic [btac_pkg::btb_index_width-1:0] raddr0;
  logic [btac_pkg::btb_index_width-1:0] raddr1;
  btac_pkg::btb_entry_t                 rdata0;
  btac_pkg::btb_entry_t                 rdata1;
  logic                                 rvalid0;
  logic                                 rvalid1;

  modport store (
    input  wen, waddr, wdata,
    input  raddr0, raddr1,
    output rdata0, rdata1, rvalid0, rvalid1
  );

  modport lookup (
    output raddr0, raddr1,
    input  rdata0, rdata1, rvalid0, rvalid1
  );

  modport update (
    output wen, waddr, wdata
  );

endinterface

// File: logic/fetch_steer.sv
`timescale 1ns/10ps

module fetch_steer (
  input  logic                      stall,
  input  logic                      clear,
  input  logic                      redirect,
  input  logic                      hit0,
  input  logic                      hit1,
  input  btac_pkg::btb_entry_t      entry0,
  input  btac_pkg::btb_entry_t      entry1,
  output logic                      pred_branch0,
  output logic                      pred_branch1,
  output logic [btac_pkg::xlen-1:0] pred_baddr,
  output logic [btac_pkg::xlen-1:0] pred_pc,
  output logic [btac_pkg::xlen-1:0] pred_npc
);

  logic                 pass;
  btac_pkg::btb_entry_t sel;

  // a pending redirect makes this fetch group stale
  assign pass = !stall && !clear && !redirect;

  // slot 0 is older, so its hit takes the entry
  assign sel = hit0 ? entry0 : entry1;

  always_comb begin
    pred_branch0 = 1'b0;
    pred_branch1 = 1'b0;
    pred_baddr   = '0;
    pred_pc      = '0;
    pred_npc     = '0;
    if (pass) begin
      pred_branch0 = hit0;
      pred_branch1 = hit1;
      pred_baddr   = sel.target;
      pred_pc      = sel.pc;
      pred_npc     = sel.npc;
    end
  end

endmodule

// File: logic/miss_resolver.sv
`timescale 1ns/10ps

module miss_resolver (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      clear,
  input  logic [btac_pkg::xlen-1:0] upd_pc0,
  input  logic [btac_pkg::xlen-1:0] upd_pc1,
  input  logic [btac_pkg::xlen-1:0] upd_npc0,
  input  logic [btac_pkg::xlen-1:0] upd_npc1,
  input  logic [btac_pkg::xlen-1:0] upd_addr0,
  input  logic [btac_pkg::xlen-1:0] upd_addr1,
  input  logic                      upd_jal0,
  input  logic                      upd_jal1,
  input  logic                      upd_branch0,
  input  logic                      upd_branch1,
  input  logic                      upd_jump0,
  input  logic                      upd_jump1,
  input  btac_pkg::pred_info_t      upd_pred0,
  input  btac_pkg::pred_info_t      upd_pred1,
  btb_port_if.update                port,
  output logic                      redirect,
  output logic [btac_pkg::xlen-1:0] redirect_addr,
  output logic                      hazard0,
  output logic                      hazard1
);

  logic                      miss0;
  logic                      miss1;
  logic [btac_pkg::xlen-1:0] maddr;
  logic                      pred_hit0;
  logic                      pred_hit1;

  // prediction belongs to this resolved instruction
  assign pred_hit0 = upd_pred0.taken && (upd_pred0.tpc == upd_pc0);
  assign pred_hit1 = upd_pred1.taken && (upd_pred1.tpc == upd_pc1);

  // install taken transfers with slot 0 winning when both jump
  always_comb begin
    port.wen   = 1'b0;
    port.waddr = '0;
    port.wdata = '0;
    if (!clear) begin
      port.wen = ((upd_jal0 || upd_branch0) && upd_jump0) ||
                 ((upd_jal1 || upd_branch1) && upd_jump1);
      if (upd_jump0) begin
        port.waddr = upd_pc0[btac_pkg::btb_index_width+1:2];
        port.wdata = '{target: upd_addr0, pc: upd_pc0, npc: upd_npc0};
      end else begin
        port.waddr = upd_pc1[btac_pkg::btb_index_width+1:2];
        port.wdata = '{target: upd_addr1, pc: upd_pc1, npc: upd_npc1};
      end
    end
  end

  always_comb begin
    miss0 = 1'b0;
    miss1 = 1'b0;
    maddr = '0;
    if (!clear) begin
      if (pred_hit0) begin
        if (upd_jump0) begin
          miss0 = (upd_addr0 != upd_pred0.taddr); // wrong target
          maddr = upd_addr0;
        end else if (upd_branch0) begin
          miss0 = 1'b1; // predicted taken but fell through
          maddr = upd_pred0.tnpc;
        end
      end else if (pred_hit1) begin
        if (upd_jump1) begin
          miss1 = (upd_addr1 != upd_pred1.taddr);
          maddr = upd_addr1;
        end else if (upd_branch1) begin
          miss1 = 1'b1;
          maddr = upd_pred1.tnpc;
        end
      end else if (upd_jump0) begin
        miss0 = 1'b1; // taken but never predicted
        maddr = upd_addr0;
      end else if (upd_jump1) begin
        miss1 = 1'b1;
        maddr = upd_addr1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      redirect      <= 1'b0;
      redirect_addr <= '0;
    end else begin
      redirect      <= miss0 || miss1;
      redirect_addr <= maddr;
    end
  end

  assign hazard0 = miss0;
  assign hazard1 = miss1;

  // only one slot may own the redirect address
  a_one_hazard: assert property (
    @(posedge clock) disable iff (!reset)
    !(hazard0 && hazard1)
  ) else $error("hazard0 and hazard1 both high");

endmodule

// File: logic/target_lookup.sv
`timescale 1ns/10ps

module target_lookup (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        clear,
  input  logic [btac_pkg::xlen-1:0]   fetch_pc0,
  input  logic [btac_pkg::xlen-1:0]   fetch_pc1,
  btb_port_if.lookup                  port,
  output logic                        hit0,
  output logic                        hit1,
  output btac_pkg::btb_entry_t        entry0,
  output btac_pkg::btb_entry_t        entry1
);

  logic [btac_pkg::xlen-1:0] pc0_q;
  logic [btac_pkg::xlen-1:0] pc1_q;

  // fetch pcs held for the tag compare in the next cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      pc0_q <= '0;
      pc1_q <= '0;
    end else if (!clear) begin
      pc0_q <= fetch_pc0;
      pc1_q <= fetch_pc1;
    end
  end

  // under clear the index of the held pc is re-sent, so the read address holds
  always_comb begin
    if (clear) begin
      port.raddr0 = pc0_q[btac_pkg::btb_index_width+1:2];
      port.raddr1 = pc1_q[btac_pkg::btb_index_width+1:2];
    end else begin
      port.raddr0 = fetch_pc0[btac_pkg::btb_index_width+1:2];
      port.raddr1 = fetch_pc1[btac_pkg::btb_index_width+1:2];
    end
  end

  // full pc as tag, so aliases on the same index never hit
  assign hit0 = port.rvalid0 && (port.rdata0.pc == pc0_q);
  assign hit1 = port.rvalid1 && (port.rdata1.pc == pc1_q);

  assign entry0 = port.rdata0;
  assign entry1 = port.rdata1;

endmodule

// File: logic/target_store.sv
`timescale 1ns/10ps

module target_store (
  input logic       clock,
  input logic       reset,
  btb_port_if.store port
);

  btac_pkg::btb_entry_t                 mem [btac_pkg::btb_entries];
  logic [btac_pkg::btb_entries-1:0]     valid;
  logic [btac_pkg::btb_index_width-1:0] raddr0_q;
  logic [btac_pkg::btb_index_width-1:0] raddr1_q;

  // entry payload qualified by the valid bit
  always_ff @(posedge clock) begin
    if (port.wen) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid    <= '0;
      raddr0_q <= '0;
      raddr1_q <= '0;
    end else begin
      raddr0_q <= port.raddr0;
      raddr1_q <= port.raddr1;
      if (port.wen) begin
        valid[port.waddr] <= 1'b1; // entries are never invalidated
      end
    end
  end

  // async read off the registered address, so a write is visible next cycle
  assign port.rdata0  = mem[raddr0_q];
  assign port.rdata1  = mem[raddr1_q];
  assign port.rvalid0 = valid[raddr0_q];
  assign port.rvalid1 = valid[raddr1_q];

  // write index from the resolver is known whenever it writes
  a_waddr_known: assert property (
    @(posedge clock) disable iff (!reset)
    port.wen |-> !$isunknown(port.waddr)
  ) else $error("btb write with unknown index");

endmodule

// File: verif/btac_tb.sv
`timescale 1ns/10ps

module btac_tb;

  localparam logic [31:0] seed = 32'hef48d83b;
  localparam int random_cycles = 400;
  localparam int redirect_timeout = 4;
  localparam logic [31:0] pc_a = 32'h0000_1040;
  localparam logic [31:0] tgt_a = 32'h0000_2000;
  localparam logic [31:0] pc_b = 32'h0000_1080;
  localparam logic [31:0] tgt_b = 32'h0000_3000;
  localparam logic [31:0] pc_c = 32'h0000_1104;
  localparam logic [31:0] tgt_c = 32'h0000_4000;
  localparam logic [31:0] pc_d = 32'h0000_1208;
  localparam logic [31:0] pc_cold = 32'h0000_5000; // index 0 and never installed here

  typedef struct packed {
    logic        b0;
    logic        b1;
    logic [31:0] baddr;
    logic [31:0] pc;
    logic [31:0] npc;
  } pred_exp_t;

  typedef struct packed {
    logic        wen;
    logic [5:0]  waddr;
    logic [31:0] target;
    logic [31:0] pc;
    logic [31:0] npc;
    logic        h0;
    logic        h1;
    logic [31:0] maddr;
  } res_exp_t;

  logic        clock;
  logic        reset;
  logic        clear;
  logic        stall;
  logic [31:0] fetch_pc0;
  logic [31:0] fetch_pc1;
  logic [31:0] upd_pc [2];
  logic [31:0] upd_npc [2];
  logic [31:0] upd_addr [2];
  logic [31:0] upd_tpc [2];
  logic [31:0] upd_taddr [2];
  logic [31:0] upd_tnpc [2];
  logic        upd_jal [2];
  logic        upd_branch [2];
  logic        upd_jump [2];
  logic        upd_taken [2];
  logic        pred_branch0;
  logic        pred_branch1;
  logic [31:0] pred_baddr;
  logic [31:0] pred_pc;
  logic [31:0] pred_npc;
  logic        redirect;
  logic [31:0] redirect_addr;
  logic        hazard0;
  logic        hazard1;

  // shadow of the buffer and the registered state
  logic [31:0] sh_target [64];
  logic [31:0] sh_pc [64];
  logic [31:0] sh_npc [64];
  logic        sh_valid [64];
  logic [31:0] m_pc0;
  logic [31:0] m_pc1;
  logic [31:0] m_raddr;
  logic        m_redirect;

  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          test_checks;
  int          test_errors;
  string       test_name;
  logic [31:0] rng;
  logic        timed_out;

  btac_top u_dut (
    .clock (clock), .reset (reset), .clear (clear), .stall (stall),
    .fetch_pc0 (fetch_pc0), .fetch_pc1 (fetch_pc1),
    .upd_pc0 (upd_pc[0]), .upd_npc0 (upd_npc[0]), .upd_addr0 (upd_addr[0]),
    .upd_jal0 (upd_jal[0]), .upd_branch0 (upd_branch[0]), .upd_jump0 (upd_jump[0]),
    .upd_taken0 (upd_taken[0]), .upd_tpc0 (upd_tpc[0]), .upd_taddr0 (upd_taddr[0]),
    .upd_tnpc0 (upd_tnpc[0]),
    .upd_pc1 (upd_pc[1]), .upd_npc1 (upd_npc[1]), .upd_addr1 (upd_addr[1]),
    .upd_jal1 (upd_jal[1]), .upd_branch1 (upd_branch[1]), .upd_jump1 (upd_jump[1]),
    .upd_taken1 (upd_taken[1]), .upd_tpc1 (upd_tpc[1]), .upd_taddr1 (upd_taddr[1]),
    .upd_tnpc1 (upd_tnpc[1]),
    .pred_branch0 (pred_branch0), .pred_branch1 (pred_branch1), .pred_baddr (pred_baddr),
    .pred_pc (pred_pc), .pred_npc (pred_npc), .redirect (redirect),
    .redirect_addr (redirect_addr), .hazard0 (hazard0), .hazard1 (hazard1)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [5:0] idx_of(input logic [31:0] pc);
    return pc[7:2];
  endfunction

  // small pc pool with four tags per index so aliases happen
  function automatic logic [31:0] pc_from(input logic [31:0] r);
    return 32'h0000_1000 | {22'd0, r[9:2], 2'b00};
  endfunction

  function automatic pred_exp_t ref_lookup(input logic stall_i, input logic clear_i,
                                           input logic redir_i);
    pred_exp_t  p;
    logic [5:0] i0;
    logic [5:0] i1;
    p = '0;
    i0 = idx_of(m_pc0);
    i1 = idx_of(m_pc1);
    if (!stall_i && !clear_i && !redir_i) begin
      p.b0 = sh_valid[i0] && (sh_pc[i0] == m_pc0);
      p.b1 = sh_valid[i1] && (sh_pc[i1] == m_pc1);
      if (p.b0) begin
        p.baddr = sh_target[i0];
        p.pc = sh_pc[i0];
        p.npc = sh_npc[i0];
      end else if (p.b1) begin
        p.baddr = sh_target[i1];
        p.pc = sh_pc[i1];
        p.npc = sh_npc[i1];
      end
    end
    return p;
  endfunction

  function automatic res_exp_t ref_resolve();
    res_exp_t r;
    logic     own0;
    logic     own1;
    logic     s;
    r = '0;
    own0 = upd_taken[0] && (upd_tpc[0] == upd_pc[0]);
    own1 = upd_taken[1] && (upd_tpc[1] == upd_pc[1]);
    s = !upd_jump[0];
    if (!clear) begin
      r.wen = ((upd_jal[0] || upd_branch[0]) && upd_jump[0]) ||
              ((upd_jal[1] || upd_branch[1]) && upd_jump[1]);
      r.waddr = idx_of(upd_pc[s]);
      r.target = upd_addr[s];
      r.pc = upd_pc[s];
      r.npc = upd_npc[s];
      if (own0) begin
        if (upd_jump[0]) begin
          r.h0 = upd_addr[0] != upd_taddr[0];
          r.maddr = upd_addr[0];
        end else if (upd_branch[0]) begin
          r.h0 = 1'b1;
          r.maddr = upd_tnpc[0];
        end
      end else if (own1) begin
        if (upd_jump[1]) begin
          r.h1 = upd_addr[1] != upd_taddr[1];
          r.maddr = upd_addr[1];
        end else if (upd_branch[1]) begin
          r.h1 = 1'b1;
          r.maddr = upd_tnpc[1];
        end
      end else if (upd_jump[0]) begin
        r.h0 = 1'b1;
        r.maddr = upd_addr[0];
      end else if (upd_jump[1]) begin
        r.h1 = 1'b1;
        r.maddr = upd_addr[1];
      end
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic draw(output logic [31:0] v);
    rng = lcg_next(rng);
    v = rng;
  endtask

  task automatic clear_updates();
    for (int s = 0; s < 2; s++) begin
      upd_pc[s] = '0;
      upd_npc[s] = '0;
      upd_addr[s] = '0;
      upd_tpc[s] = '0;
      upd_taddr[s] = '0;
      upd_tnpc[s] = '0;
      upd_jal[s] = 1'b0;
      upd_branch[s] = 1'b0;
      upd_jump[s] = 1'b0;
      upd_taken[s] = 1'b0;
    end
  endtask

  task automatic tick();
    @(negedge clock);
    clear_updates(); // updates last a single cycle
  endtask

  task automatic settle();
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("%s: %0d checks, %0d errors", test_name, n_checks - test_checks,
             n_errors - test_errors);
  endtask

  task automatic expect_redirect(input logic [31:0] exp_addr);
    int   waited;
    logic seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < redirect_timeout) begin
      tick();
      settle();
      seen = redirect;
      waited++;
    end
    if (seen) begin
      check("redirect_addr", redirect_addr, exp_addr);
    end else begin
      $display("timeout: no redirect to %h within %0d cycles", exp_addr, redirect_timeout);
      timed_out = 1'b1;
    end
  endtask

  task automatic random_slot(input logic s);
    logic [31:0] r;
    logic [31:0] a;
    draw(r);
    draw(a);
    upd_pc[s] = pc_from(r);
    upd_npc[s] = upd_pc[s] + 32'd4;
    upd_addr[s] = pc_from(a);
    upd_jal[s] = r[12] & r[13];
    upd_branch[s] = r[14];
    upd_jump[s] = upd_jal[s] | (r[15] & r[16]);
    upd_taken[s] = r[17];
    upd_tpc[s] = r[18] ? upd_pc[s] : pc_from(a >> 10);
    upd_taddr[s] = r[19] ? upd_addr[s] : pc_from(r >> 20);
    upd_tnpc[s] = upd_pc[s] + 32'd4;
  endtask

  // compares every cycle once the falling-edge inputs have settled
  initial begin : compare
    pred_exp_t ep;
    res_exp_t  er;
    forever begin
      @(negedge clock);
      settle();
      if (!reset) begin
        sh_valid = '{default: 1'b0};
        m_pc0 = '0;
        m_pc1 = '0;
        m_redirect = 1'b0;
        m_raddr = '0;
      end else begin
        ep = ref_lookup(stall, clear, m_redirect);
        er = ref_resolve();
        check("pred_branch0", 32'(pred_branch0), 32'(ep.b0));
        check("pred_branch1", 32'(pred_branch1), 32'(ep.b1));
        if (stall || clear || m_redirect || ep.b0 || ep.b1) begin
          check("pred_baddr", pred_baddr, ep.baddr);
          check("pred_pc", pred_pc, ep.pc);
          check("pred_npc", pred_npc, ep.npc);
        end
        check("hazard0", 32'(hazard0), 32'(er.h0));
        check("hazard1", 32'(hazard1), 32'(er.h1));
        check("redirect", 32'(redirect), 32'(m_redirect));
        if (m_redirect) begin
          check("redirect_addr (model)", redirect_addr, m_raddr);
        end
        if (er.wen) begin
          sh_target[er.waddr] = er.target;
          sh_pc[er.waddr] = er.pc;
          sh_npc[er.waddr] = er.npc;
          sh_valid[er.waddr] = 1'b1;
        end
        if (!clear) begin
          m_pc0 = fetch_pc0; // held under clear
          m_pc1 = fetch_pc1;
        end
        m_redirect = er.h0 || er.h1;
        m_raddr = er.maddr;
      end
    end
  end

  task automatic after_reset();
    logic [31:0] r;
    begin_test("after_reset");
    for (int n = 0; n < 8; n++) begin
      tick();
      draw(r);
      fetch_pc0 = pc_from(r);
      fetch_pc1 = pc_from(r >> 12);
      settle();
      check("pred_branch0 after reset", 32'(pred_branch0), 32'd0);
      check("pred_branch1 after reset", 32'(pred_branch1), 32'd0);
      check("redirect after reset", 32'(redirect), 32'd0);
    end
    end_test();
  endtask

  task automatic install_and_hit();
    begin_test("install_and_hit");
    tick();
    fetch_pc0 = pc_a;
    fetch_pc1 = pc_a + 32'h100; // same index with another tag
    upd_jal[0] = 1'b1;
    upd_jump[0] = 1'b1;
    upd_pc[0] = pc_a;
    upd_addr[0] = tgt_a;
    upd_npc[0] = pc_a + 32'd4;
    settle();
    check("hazard0 on unpredicted jal", 32'(hazard0), 32'd1);
    expect_redirect(tgt_a);
    tick();
    settle();
    check("pred_branch0 on installed pc", 32'(pred_branch0), 32'd1);
    check("pred_branch1 on alias", 32'(pred_branch1), 32'd0);
    check("pred_baddr", pred_baddr, tgt_a);
    check("pred_pc", pred_pc, pc_a);
    check("pred_npc", pred_npc, pc_a + 32'd4);
    end_test();
  endtask

  task automatic dual_slot_hit();
    begin_test("dual_slot_hit");
    tick();
    upd_branch[1] = 1'b1;
    upd_jump[1] = 1'b1;
    upd_pc[1] = pc_b;
    upd_addr[1] = tgt_b;
    upd_npc[1] = pc_b + 32'd4;
    settle();
    check("hazard1 on unpredicted branch", 32'(hazard1), 32'd1);
    expect_redirect(tgt_b);
    tick();
    fetch_pc0 = pc_a;
    fetch_pc1 = pc_b;
    tick();
    fetch_pc0 = pc_cold;
    settle();
    check("both hit, pred_branch0", 32'(pred_branch0), 32'd1);
    check("both hit, pred_branch1", 32'(pred_branch1), 32'd1);
    check("both hit, pred_baddr", pred_baddr, tgt_a);
    check("both hit, pred_pc", pred_pc, pc_a);
    tick();
    settle();
    check("slot 1 hit, pred_branch0", 32'(pred_branch0), 32'd0);
    check("slot 1 hit, pred_branch1", 32'(pred_branch1), 32'd1);
    check("slot 1 hit, pred_baddr", pred_baddr, tgt_b);
    check("slot 1 hit, pred_pc", pred_pc, pc_b);
    check("slot 1 hit, pred_npc", pred_npc, pc_b + 32'd4);
    end_test();
  endtask

  task automatic resolve_cases();
    begin_test("resolve_cases");
    tick(); // correct prediction
    upd_jal[0] = 1'b1;
    upd_jump[0] = 1'b1;
    upd_pc[0] = pc_a;
    upd_addr[0] = tgt_a;
    upd_npc[0] = pc_a + 32'd4;
    upd_taken[0] = 1'b1;
    upd_tpc[0] = pc_a;
    upd_taddr[0] = tgt_a;
    upd_tnpc[0] = pc_a + 32'd4;
    settle();
    check("correct, hazard0", 32'(hazard0), 32'd0);
    check("correct, hazard1", 32'(hazard1), 32'd0);
    tick();
    settle();
    check("correct, redirect", 32'(redirect), 32'd0);
    tick(); // wrong target
    upd_branch[0] = 1'b1;
    upd_jump[0] = 1'b1;
    upd_pc[0] = pc_a;
    upd_addr[0] = tgt_a + 32'h100;
    upd_npc[0] = pc_a + 32'd4;
    upd_taken[0] = 1'b1;
    upd_tpc[0] = pc_a;
    upd_taddr[0] = tgt_a;
    settle();
    check("wrong target, hazard0", 32'(hazard0), 32'd1);
    expect_redirect(tgt_a + 32'h100);
    tick(); // predicted taken but fell through
    upd_branch[1] = 1'b1;
    upd_pc[1] = pc_b;
    upd_taken[1] = 1'b1;
    upd_tpc[1] = pc_b;
    upd_taddr[1] = tgt_b;
    upd_tnpc[1] = pc_b + 32'd4;
    settle();
    check("not taken, hazard0", 32'(hazard0), 32'd0);
    check("not taken, hazard1", 32'(hazard1), 32'd1);
    expect_redirect(pc_b + 32'd4);
    tick(); // unpredicted jump on slot 1
    upd_jal[1] = 1'b1;
    upd_jump[1] = 1'b1;
    upd_pc[1] = pc_c;
    upd_addr[1] = tgt_c;
    upd_npc[1] = pc_c + 32'd4;
    settle();
    check("unpredicted slot 1, hazard1", 32'(hazard1), 32'd1);
    expect_redirect(tgt_c);
    end_test();
  endtask

  task automatic stall_and_clear();
    begin_test("stall_and_clear");
    tick();
    fetch_pc0 = pc_a;
    fetch_pc1 = pc_cold;
    tick();
    stall = 1'b1;
    settle();
    check("stalled pred_branch0", 32'(pred_branch0), 32'd0);
    check("stalled pred_baddr", pred_baddr, 32'd0);
    tick();
    stall = 1'b0;
    settle();
    check("unstalled pred_branch0", 32'(pred_branch0), 32'd1);
    tick();
    clear = 1'b1;
    fetch_pc0 = pc_cold;
    upd_jal[0] = 1'b1;
    upd_jump[0] = 1'b1;
    upd_pc[0] = pc_d;
    upd_addr[0] = 32'h0000_6000;
    settle();
    check("cleared pred_branch0", 32'(pred_branch0), 32'd0);
    check("cleared hazard0", 32'(hazard0), 32'd0);
    tick();
    clear = 1'b0;
    fetch_pc0 = pc_d;
    settle();
    check("held lookup, pred_branch0", 32'(pred_branch0), 32'd1);
    check("held lookup, pred_pc", pred_pc, pc_a);
    check("redirect blocked by clear", 32'(redirect), 32'd0);
    tick();
    settle();
    check("write blocked by clear", 32'(pred_branch0), 32'd0);
    end_test();
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    begin_test("random_traffic");
    for (int n = 0; n < random_cycles; n++) begin
      tick();
      draw(r);
      stall = (r[2:0] == 3'd0);
      clear = (r[6:3] == 4'd0);
      fetch_pc0 = pc_from(r >> 8);
      fetch_pc1 = pc_from(r >> 18);
      if (r[29:28] == 2'd0) begin
        random_slot(1'b0);
      end
      if (r[31:30] == 2'd0) begin
        random_slot(1'b1);
      end
      if (r[7]) begin
        fetch_pc0 = upd_pc[0]; // lookup of the index being written
      end
    end
    tick();
    stall = 1'b0;
    clear = 1'b0;
    end_test();
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 10);
    rng = seed;
    n_checks = 0;
    n_errors = 0;
    n_tests = 0;
    timed_out = 1'b0;
    reset = 1'b0;
    clear = 1'b0;
    stall = 1'b0;
    fetch_pc0 = '0;
    fetch_pc1 = '0;
    clear_updates();
    repeat (4) @(negedge clock);
    reset = 1'b1;
    after_reset();
    if (!timed_out) install_and_hit();
    if (!timed_out) dual_slot_hit();
    if (!timed_out) resolve_cases();
    if (!timed_out) stall_and_clear();
    if (!timed_out) random_traffic();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
